/* filelist.f */
design/cache_pkg.sv
design/cache_array_if.sv
design/mem_if.sv
design/cpu_req_port.sv
design/cache_controller.sv
design/cache_array.sv
design/main_memory.sv
design/cpu_resp_port.sv
design/cache_system.sv
dv/cache_system_assert.sv
dv/cache_system_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
rm -f build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module cache_system_tb \
    -f filelist.f -o cache_sim > build.log 2>&1 &&
    ./obj_dir/cache_sim > sim.log 2>&1
grep -qx "Testbench passed" sim.log && echo "Simulation passed, see sim.log" && exit 0 ||
    { echo "Simulation did not pass, see build.log and sim.log"; exit 1; }

/* dv/cache_system_tb.sv */
`timescale 1ns/1ps

module cache_system_tb import cache_pkg::*; ();

    localparam int num_requests = 213;
    localparam int cycle_limit  = num_requests * (8 * (mem_wait + 1) + 10) + 200;

    logic                 clk;
    logic                 reset;
    logic                 req_valid;
    logic                 req_ready;
    cache_op_e            req_op;
    logic [addr_w-1:0]    req_addr;
    logic [data_w-1:0]    req_wdata;
    logic                 resp_valid;
    logic                 resp_ready;
    logic [data_w-1:0]    resp_rdata;
    logic                 resp_hit;

    // Reference model with one line per index
    logic [data_w-1:0]    model_mem [mem_words];
    logic [tag_w-1:0]     model_tag [num_lines];
    logic [num_lines-1:0] model_valid;
    logic [num_lines-1:0] model_dirty;

    int data_errors    = 0;
    int hit_errors     = 0;
    int latency_errors = 0;
    int other_errors   = 0;
    int total_errors   = 0;
    int req_num        = 0;
    int cycle_cnt      = 0;
    int seed           = 81787;

    cache_system cache_system_inst (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_op     (req_op),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp_rdata (resp_rdata),
        .resp_hit   (resp_hit)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout: request %0d at address %h never completed", req_num, req_addr);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_data(input string name, input logic [data_w-1:0] exp,
                              input logic [data_w-1:0] act);
        if (act !== exp) begin
            data_errors++;
            $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_hit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            hit_errors++;
            $display("Fail at %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        if (act != exp) begin
            latency_errors++;
            $display("Fail at %0t: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    // Write-allocate so a miss always brings the line in
    task automatic model_access(input cache_op_e op, input logic [addr_w-1:0] addr,
                                input logic [data_w-1:0] wdata,
                                output logic [data_w-1:0] exp_data, output logic exp_hit,
                                output int exp_cycles);
        logic [index_w-1:0] idx;
        logic [tag_w-1:0]   tag;
        idx = addr[offset_w +: index_w];
        tag = addr[addr_w-1 -: tag_w];
        exp_hit = model_valid[idx] && (model_tag[idx] == tag);
        // A dirty victim costs a whole line of write-back first
        if (exp_hit) begin
            exp_cycles = 2;
        end else if (model_valid[idx] && model_dirty[idx]) begin
            exp_cycles = 2 * words_per_line * (mem_wait + 1) + 3;
        end else begin
            exp_cycles = words_per_line * (mem_wait + 1) + 3;
        end
        if (!exp_hit) begin
            model_valid[idx] = 1'b1;
            model_tag[idx]   = tag;
            model_dirty[idx] = 1'b0;
        end
        if (op == OP_WRITE) begin
            model_mem[addr]  = wdata;
            model_dirty[idx] = 1'b1;
        end
        exp_data = model_mem[addr];
    endtask

    // hold is the number of cycles resp_ready stays low once resp_valid is up
    task automatic do_request(input cache_op_e op, input logic [addr_w-1:0] addr,
                              input logic [data_w-1:0] wdata, input int hold);
        logic [data_w-1:0] exp_data;
        logic              exp_hit;
        int                exp_cycles;
        int                cycles;
        logic [data_w-1:0] held_data;
        logic              held_hit;
        model_access(op, addr, wdata, exp_data, exp_hit, exp_cycles);
        req_num++;
        req_op     = op;
        req_addr   = addr;
        req_wdata  = wdata;
        req_valid  = 1'b1;
        resp_ready = (hold == 0);
        while (!req_ready) begin
            next_cycle();
        end
        next_cycle();
        req_valid = 1'b0;
        // Counted from the handshake cycle to the first cycle with resp_valid
        cycles = 1;
        while (!resp_valid) begin
            next_cycle();
            cycles++;
        end
        check_latency("resp_valid latency", exp_cycles, cycles);
        held_data = resp_rdata;
        held_hit  = resp_hit;
        for (int i = 0; i < hold; i++) begin
            next_cycle();
            check_data("resp_rdata", held_data, resp_rdata);
            check_hit("resp_hit", held_hit, resp_hit);
            if (!resp_valid || req_ready) begin
                other_errors++;
                $display("Error at %0t: response dropped or new request allowed", $time);
            end
        end
        check_data("resp_rdata", exp_data, resp_rdata);
        check_hit("resp_hit", exp_hit, resp_hit);
        resp_ready = 1'b1;
        next_cycle();
    endtask

    task automatic test_reset_and_first_read();
        if (!req_ready || resp_valid) begin
            other_errors++;
            $display("Error at %0t: handshake outputs wrong after reset", $time);
        end
        do_request(OP_READ, 12'h010, '0, 0);
        do_request(OP_READ, 12'h010, '0, 0);
    endtask

    task automatic test_write_hit();
        do_request(OP_WRITE, 12'h011, 16'hbeef, 0);
        for (int i = 0; i < words_per_line; i++) begin
            do_request(OP_READ, 12'h010 + addr_w'(i), '0, 0);
        end
    endtask

    task automatic test_write_miss();
        do_request(OP_WRITE, 12'h0a8, 16'h5a5a, 0);
        do_request(OP_READ, 12'h0a8, '0, 0);
    endtask

    // Same index with another tag sends the dirty line back to memory
    task automatic test_dirty_evict();
        do_request(OP_WRITE, 12'h0c4, 16'h1234, 0);
        do_request(OP_READ, 12'h4c4, '0, 0);
        do_request(OP_READ, 12'h0c4, '0, 0);
    endtask

    task automatic test_back_pressure();
        do_request(OP_READ, 12'h0c4, '0, 6);
    endtask

    // Two tags and four indices
    task automatic test_random();
        logic [31:0] rnd;
        for (int n = 0; n < 200; n++) begin
            rnd = $random(seed);
            do_request(rnd[5] ? OP_WRITE : OP_READ,
                       {5'd0, rnd[0], 2'b00, rnd[2:1], rnd[4:3]}, rnd[31:16], 0);
        end
    endtask

    initial begin
        reset       = 1'b1;
        req_valid   = 1'b0;
        req_op      = OP_READ;
        req_addr    = '0;
        req_wdata   = '0;
        resp_ready  = 1'b1;
        model_valid = '0;
        model_dirty = '0;
        for (int i = 0; i < mem_words; i++) begin
            model_mem[i] = '0;
        end
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        test_reset_and_first_read();
        test_write_hit();
        test_write_miss();
        test_dirty_evict();
        test_back_pressure();
        test_random();

        total_errors = data_errors + hit_errors + latency_errors + other_errors
                     + cache_system_inst.cache_system_assert_inst.assert_errors;
        $display("Errors: data %0d, hit %0d, latency %0d, other %0d, assertion %0d",
                 data_errors, hit_errors, latency_errors, other_errors,
                 cache_system_inst.cache_system_assert_inst.assert_errors);
        if (total_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* dv/cache_system_assert.sv */
`timescale 1ns/1ps

module cache_system_assert import cache_pkg::*; (
    input logic              clk,
    input logic              reset,
    input logic              req_ready,
    input logic              resp_valid,
    input logic              resp_ready,
    input logic [data_w-1:0] resp_rdata,
    input logic              resp_hit,
    input logic              read_mem,
    input logic              write_mem
);

    int assert_errors = 0;

    // Pending response blocks new requests
    ready_blocked: assert property (@(posedge clk) disable iff (reset)
        resp_valid |-> !req_ready)
        else begin
            assert_errors++;
            $error("req_ready high while a response is pending");
        end

    resp_stable: assert property (@(posedge clk) disable iff (reset)
        (resp_valid && !resp_ready) |=> resp_valid && $stable(resp_rdata) && $stable(resp_hit))
        else begin
            assert_errors++;
            $error("response changed while stalled");
        end

    mem_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(read_mem && write_mem))
        else begin
            assert_errors++;
            $error("memory read and write requested together");
        end

    reset_clears_resp: assert property (@(posedge clk) reset |=> !resp_valid)
        else begin
            assert_errors++;
            $error("resp_valid high after reset");
        end

endmodule

bind cache_system cache_system_assert cache_system_assert_inst (
    .clk        (clk),
    .reset      (reset),
    .req_ready  (req_ready),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .resp_rdata (resp_rdata),
    .resp_hit   (resp_hit),
    .read_mem   (mem_bus.read_mem),
    .write_mem  (mem_bus.write_mem)
);

/* design/cache_system.sv */
`timescale 1ns/1ps

module cache_system import cache_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                req_valid,
    output logic                req_ready,
    input  cache_op_e           req_op,
    input  logic [addr_w-1:0]   req_addr,
    input  logic [data_w-1:0]   req_wdata,
    output logic                resp_valid,
    input  logic                resp_ready,
    output logic [data_w-1:0]   resp_rdata,
    output logic                resp_hit
);

    logic                pend_valid;
    cache_op_e           pend_op;
    logic [addr_w-1:0]   pend_addr;
    logic [data_w-1:0]   pend_wdata;
    logic                done;
    logic                done_hit;
    logic [data_w-1:0]   done_rdata;

    cache_array_if arr_bus ();
    mem_if         mem_bus ();

    cpu_req_port cpu_req_port_inst (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_op     (req_op),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .resp_valid (resp_valid),
        .done       (done),
        .pend_valid (pend_valid),
        .pend_op    (pend_op),
        .pend_addr  (pend_addr),
        .pend_wdata (pend_wdata)
    );

    cache_controller cache_controller_inst (
        .clk        (clk),
        .reset      (reset),
        .pend_valid (pend_valid),
        .pend_op    (pend_op),
        .pend_addr  (pend_addr),
        .pend_wdata (pend_wdata),
        .done       (done),
        .done_hit   (done_hit),
        .done_rdata (done_rdata),
        .arr        (arr_bus.controller),
        .mem        (mem_bus.controller)
    );

    cache_array cache_array_inst (
        .clk   (clk),
        .reset (reset),
        .arr   (arr_bus.array)
    );

    main_memory main_memory_inst (
        .clk   (clk),
        .reset (reset),
        .mem   (mem_bus.memory)
    );

    cpu_resp_port cpu_resp_port_inst (
        .clk        (clk),
        .reset      (reset),
        .done       (done),
        .done_hit   (done_hit),
        .done_rdata (done_rdata),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp_rdata (resp_rdata),
        .resp_hit   (resp_hit)
    );

endmodule

/* design/cpu_resp_port.sv */
`timescale 1ns/1ps

module cpu_resp_port import cache_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                done,
    input  logic                done_hit,
    input  logic [data_w-1:0]   done_rdata,
    output logic                resp_valid,
    input  logic                resp_ready,
    output logic [data_w-1:0]   resp_rdata,
    output logic                resp_hit
);

    always_ff @(posedge clk) begin
        if (reset) begin
            resp_valid <= 1'b0;
        end else if (done) begin
            resp_valid <= 1'b1;
        end else if (resp_ready) begin
            resp_valid <= 1'b0;
        end
    end

    // Payload only moves on done, so it stays put under back-pressure
    always_ff @(posedge clk) begin
        if (done) begin
            resp_rdata <= done_rdata;
            resp_hit   <= done_hit;
        end
    end

endmodule

/* design/main_memory.sv */
`timescale 1ns/1ps

module main_memory import cache_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    mem_if.memory    mem
);

    logic [data_w-1:0]     mem_array [mem_words];
    logic [wait_cnt_w-1:0] wait_cnt;
    logic                  access;

    initial begin
        for (int i = 0; i < mem_words; i++) begin
            mem_array[i] = '0;
        end
    end

    assign access    = mem.read_mem || mem.write_mem;
    assign mem.stall = access && (wait_cnt != wait_cnt_w'(mem_wait));
    assign mem.rdata = mem_array[mem.addr];

    // Counts stall cycles, restarts after each completed word
    always_ff @(posedge clk) begin
        if (reset) begin
            wait_cnt <= '0;
        end else if (!access) begin
            wait_cnt <= '0;
        end else if (mem.stall) begin
            wait_cnt <= wait_cnt + 1'b1;
        end else begin
            wait_cnt <= '0;
        end
    end

    always @(posedge clk) begin
        if (mem.write_mem && !mem.stall) begin
            mem_array[mem.addr] <= mem.wdata;
        end
    end

endmodule

/* design/cache_array.sv */
`timescale 1ns/1ps

module cache_array import cache_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    cache_array_if.array  arr
);

    logic [tag_w-1:0]     tag_mem  [num_lines];
    logic [data_w-1:0]    data_mem [num_lines][words_per_line];
    logic [num_lines-1:0] valid_bits;
    logic [num_lines-1:0] dirty_bits;
    logic                 tag_match;

    assign arr.valid   = valid_bits[arr.index];
    assign arr.dirty   = dirty_bits[arr.index];
    assign arr.tag_out = tag_mem[arr.index];
    assign arr.rdata   = data_mem[arr.index][arr.offset];

    assign tag_match = (tag_mem[arr.index] == arr.tag_in);
    assign arr.hit   = arr.comp && valid_bits[arr.index] && tag_match;

    // Line state
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (arr.write) begin
            dirty_bits[arr.index] <= arr.dirty_in;
            if (!arr.comp) begin
                valid_bits[arr.index] <= arr.valid_in;
            end
        end
    end

    // Fill writes also replace the tag
    always_ff @(posedge clk) begin
        if (arr.write) begin
            data_mem[arr.index][arr.offset] <= arr.wdata;
            if (!arr.comp) begin
                tag_mem[arr.index] <= arr.tag_in;
            end
        end
    end

endmodule

/* design/cache_controller.sv */
`timescale 1ns/1ps

module cache_controller import cache_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                pend_valid,
    input  cache_op_e           pend_op,
    input  logic [addr_w-1:0]   pend_addr,
    input  logic [data_w-1:0]   pend_wdata,
    output logic                done,
    output logic                done_hit,
    output logic [data_w-1:0]   done_rdata,
    cache_array_if.controller   arr,
    mem_if.controller           mem
);

    ctrl_state_e         state;
    ctrl_state_e         next_state;
    logic [offset_w-1:0] word_cnt;
    logic                cnt_clr;
    logic                cnt_inc;
    logic                last_word;
    logic                is_write;
    logic                filling;
    logic                line_phase;
    logic [tag_w-1:0]    pend_tag;
    logic [index_w-1:0]  pend_index;
    logic [offset_w-1:0] pend_offset;

    assign {pend_tag, pend_index, pend_offset} = pend_addr;

    assign is_write   = (pend_op == OP_WRITE);
    assign last_word  = (word_cnt == offset_w'(words_per_line - 1));
    assign filling    = (state == ST_FILL) || (state == ST_FILL_WAIT);
    assign line_phase = filling || (state == ST_WRITE_BACK);

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ST_IDLE;
            word_cnt <= '0;
        end else begin
            state <= next_state;
            if (cnt_clr) begin
                word_cnt <= '0;
            end else if (cnt_inc) begin
                word_cnt <= word_cnt + 1'b1;
            end
        end
    end

    // Address and data steering
    assign arr.index  = pend_index;
    assign arr.tag_in = pend_tag;
    assign arr.offset = line_phase ? word_cnt : pend_offset;
    assign arr.wdata  = filling ? mem.rdata : pend_wdata;
    assign mem.wdata  = arr.rdata;
    assign mem.addr   = (state == ST_WRITE_BACK) ? {arr.tag_out, pend_index, word_cnt}
                                                 : {pend_tag, pend_index, word_cnt};

    // Writes answer with the stored word
    assign done_rdata = is_write ? pend_wdata : arr.rdata;

    always_comb begin
        next_state    = state;
        cnt_clr       = 1'b0;
        cnt_inc       = 1'b0;
        arr.comp      = 1'b0;
        arr.write     = 1'b0;
        arr.valid_in  = 1'b0;
        arr.dirty_in  = 1'b0;
        mem.read_mem  = 1'b0;
        mem.write_mem = 1'b0;
        done          = 1'b0;
        done_hit      = 1'b0;

        case (state)
            ST_IDLE: begin
                cnt_clr = 1'b1;
                if (pend_valid) begin
                    arr.comp = 1'b1;
                    if (arr.hit) begin
                        done         = 1'b1;
                        done_hit     = 1'b1;
                        arr.write    = is_write;
                        arr.dirty_in = 1'b1;
                    end else if (arr.valid && arr.dirty) begin
                        next_state = ST_WRITE_BACK;
                    end else begin
                        next_state = ST_FILL;
                    end
                end
            end
            ST_WRITE_BACK: begin
                mem.write_mem = 1'b1;
                if (!mem.stall) begin
                    cnt_inc = 1'b1;
                    if (last_word) begin
                        cnt_clr    = 1'b1;
                        next_state = ST_FILL;
                    end
                end
            end
            ST_FILL, ST_FILL_WAIT: begin
                mem.read_mem = 1'b1;
                arr.valid_in = 1'b1;
                if (!mem.stall) begin
                    arr.write = 1'b1;
                    cnt_inc   = 1'b1;
                    if (last_word) begin
                        cnt_clr    = 1'b1;
                        next_state = is_write ? ST_WRITE_ALLOC : ST_DONE;
                    end else begin
                        next_state = ST_FILL;
                    end
                end else begin
                    next_state = ST_FILL_WAIT;
                end
            end
            ST_WRITE_ALLOC: begin
                // Line is resident now, store the word and mark dirty
                arr.comp     = 1'b1;
                arr.write    = 1'b1;
                arr.dirty_in = 1'b1;
                done         = 1'b1;
                next_state   = ST_IDLE;
            end
            ST_DONE: begin
                done       = 1'b1;
                next_state = ST_IDLE;
            end
            default: begin
                next_state = ST_IDLE;
            end
        endcase
    end

endmodule

/* design/cpu_req_port.sv */
`timescale 1ns/1ps

module cpu_req_port import cache_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                req_valid,
    output logic                req_ready,
    input  cache_op_e           req_op,
    input  logic [addr_w-1:0]   req_addr,
    input  logic [data_w-1:0]   req_wdata,
    input  logic                resp_valid,
    input  logic                done,
    output logic                pend_valid,
    output cache_op_e           pend_op,
    output logic [addr_w-1:0]   pend_addr,
    output logic [data_w-1:0]   pend_wdata
);

    logic accept;

    // A blocked response also blocks new requests
    assign req_ready = !pend_valid && !resp_valid;
    assign accept    = req_valid && req_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            pend_valid <= 1'b0;
        end else if (accept) begin
            pend_valid <= 1'b1;
        end else if (done) begin
            pend_valid <= 1'b0;
        end
    end

    // Held until the controller reports done
    always_ff @(posedge clk) begin
        if (accept) begin
            pend_op    <= req_op;
            pend_addr  <= req_addr;
            pend_wdata <= req_wdata;
        end
    end

endmodule

/* design/mem_if.sv */
`timescale 1ns/1ps

interface mem_if import cache_pkg::*; ();

    logic                read_mem;
    logic                write_mem;
    logic [addr_w-1:0]   addr;
    logic [data_w-1:0]   wdata;

    // Word completes when a request is up and stall is low
    logic [data_w-1:0]   rdata;
    logic                stall;

    modport controller (
        output read_mem, write_mem, addr, wdata,
        input  rdata, stall
    );

    modport memory (
        input  read_mem, write_mem, addr, wdata,
        output rdata, stall
    );

endinterface

/* design/cache_array_if.sv */
`timescale 1ns/1ps

interface cache_array_if import cache_pkg::*; ();

    // Controller to array
    logic [index_w-1:0]  index;
    logic [offset_w-1:0] offset;
    logic [tag_w-1:0]    tag_in;
    logic [data_w-1:0]   wdata;
    logic                comp;
    logic                write;
    logic                valid_in;
    logic                dirty_in;

    // Array to controller, combinational from index and offset
    logic                hit;
    logic                valid;
    logic                dirty;
    logic [tag_w-1:0]    tag_out;
    logic [data_w-1:0]   rdata;

    modport controller (
        output index, offset, tag_in, wdata, comp, write, valid_in, dirty_in,
        input  hit, valid, dirty, tag_out, rdata
    );

    modport array (
        input  index, offset, tag_in, wdata, comp, write, valid_in, dirty_in,
        output hit, valid, dirty, tag_out, rdata
    );

endinterface

/* design/cache_pkg.sv */
package cache_pkg;

    // Word and address sizes
    localparam int data_w   = 16;
    localparam int addr_w   = 12;

    // Address split: tag | index | offset
    localparam int offset_w = 2;
    localparam int index_w  = 4;
    localparam int tag_w    = addr_w - index_w - offset_w;

    localparam int words_per_line = 4;
    localparam int num_lines      = 2 ** index_w;

    // Backing memory
    localparam int mem_wait   = 2;
    localparam int mem_words  = 2 ** addr_w;
    localparam int wait_cnt_w = $clog2(mem_wait + 1);

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } cache_op_e;

    // Miss sequence: write back, fill, wait, allocate or done
    typedef enum logic [2:0] {
        ST_IDLE        = 3'd0,
        ST_WRITE_BACK  = 3'd1,
        ST_FILL        = 3'd2,
        ST_FILL_WAIT   = 3'd3,
        ST_WRITE_ALLOC = 3'd4,
        ST_DONE        = 3'd5
    } ctrl_state_e;

endpackage
